// File: project.f
rtl/tl_pkg.sv
rtl/acc_fifo.sv
rtl/power_calc.sv
rtl/dll_update.sv
rtl/tracking_loop_top.sv
sim/tb_clock.sv
sim/tb_tracking_loop.sv

// File: rtl/acc_fifo.sv
`timescale 1ns/1ps

module acc_fifo
   import tl_pkg::*;
(
   input  logic     clk,
   input  logic     i_arst_n,
   input  logic     i_push,
   input  acc_rec_t i_data,
   input  logic     i_pop,
   output logic     o_empty,
   output acc_rec_t o_head,
   output logic     o_overflow
);

   acc_rec_t             mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0]   wr_ptr;
   logic [FIFO_AW-1:0]   rd_ptr;
   logic [FIFO_CW-1:0]   count;
   logic                 full;
   logic                 do_push;
   logic                 do_pop;

   assign o_empty = (count == '0);
   assign full    = (count == FIFO_CW'(FIFO_DEPTH));

   // A pop in the same cycle makes room for the push.
   assign do_pop  = i_pop && !o_empty;
   assign do_push = i_push && (!full || do_pop);

   // Oldest record is always on the head.
   assign o_head = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         o_overflow <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Dropped record, flag stays until reset.
         if (i_push && !do_push) begin
            o_overflow <= 1'b1;
         end
      end
   end

endmodule

// File: rtl/dll_update.sv
`timescale 1ns/1ps

module dll_update
   import tl_pkg::*;
(
   input  logic              clk,
   input  logic              i_arst_n,
   input  logic              i_pwr_valid,
   input  pwr_rec_t          i_pwr,
   input  logic [TAG_W-1:0]  i_host_addr,
   input  logic              i_host_wr,
   input  logic [TAU_W-1:0]  i_host_wdata,
   output logic [TAU_W-1:0]  o_host_rdata,
   output logic              o_update_valid,
   output dll_result_t       o_update
);

   // Code phase per tag.
   logic [TAU_W-1:0]         tau_tab [NUM_TAGS];
   logic signed [DISC_W-1:0] disc;
   logic signed [DISC_W-1:0] step;
   logic [TAU_W-1:0]         tau_new;

   //////////////////////////////////////////////////////////////////////
   // Discriminator
   //////////////////////////////////////////////////////////////////////

   // Early minus late power; prompt is not part of the code loop.
   always_comb begin
      disc    = $signed({1'b0, i_pwr.pwr_early}) - $signed({1'b0, i_pwr.pwr_late});
      step    = disc >>> DLL_GAIN_SHIFT;
      // Tau wraps modulo 2^TAU_W.
      tau_new = tau_tab[i_pwr.tag] + step[TAU_W-1:0];
   end

   //////////////////////////////////////////////////////////////////////
   // Tau table and host port
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int k = 0; k < NUM_TAGS; k++) begin
            tau_tab[k] <= '0;
         end
         o_host_rdata   <= '0;
         o_update_valid <= 1'b0;
      end else begin
         o_host_rdata   <= tau_tab[i_host_addr];
         o_update_valid <= i_pwr_valid;
         if (i_host_wr) begin
            tau_tab[i_host_addr] <= i_host_wdata;
         end
         // Loop update comes last so it wins on the same tag.
         if (i_pwr_valid) begin
            tau_tab[i_pwr.tag] <= tau_new;
         end
      end
   end

   // Result report.
   always_ff @(posedge clk) begin
      if (i_pwr_valid) begin
         o_update.tag  <= i_pwr.tag;
         o_update.disc <= disc;
         o_update.tau  <= tau_new;
      end
   end

endmodule

// File: rtl/power_calc.sv
`timescale 1ns/1ps

module power_calc
   import tl_pkg::*;
(
   input  logic     clk,
   input  logic     i_arst_n,
   input  logic     i_empty,
   input  acc_rec_t i_head,
   output logic     o_pop,
   output logic     o_pwr_valid,
   output pwr_rec_t o_pwr
);

   pwr_phase_e              phase;
   pwr_phase_e              ph_sq;
   pwr_phase_e              ph_sum;
   logic signed [ACC_W-1:0] i_sel;
   logic signed [ACC_W-1:0] q_sel;
   // One extra bit holds the magnitude of the most negative input.
   logic [MAG_W:0]          i_mag;
   logic [MAG_W:0]          q_mag;
   logic [PWR_W-1:0]        i_sq;
   logic [PWR_W-1:0]        q_sq;
   logic [PWR_W-1:0]        pwr_sum;
   logic [TAG_W-1:0]        tag_sq;
   logic [TAG_W-1:0]        tag_sum;

   function automatic logic [MAG_W:0] abs_mag(input logic signed [ACC_W-1:0] v);
      logic [MAG_W:0] m;
      m = v[ACC_W-1] ? -v : v;
      return m;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Phase sequencer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         phase <= PH_IDLE;
      end else begin
         case (phase)
            PH_IDLE: begin
               if (!i_empty) begin
                  phase <= PH_EARLY;
               end
            end
            PH_EARLY:  phase <= PH_PROMPT;
            PH_PROMPT: phase <= PH_LATE;
            default:   phase <= PH_IDLE;
         endcase
      end
   end

   // Record leaves the FIFO once late I/Q is taken.
   assign o_pop = (phase == PH_LATE);

   // Subchannel select.
   always_comb begin
      case (phase)
         PH_EARLY: begin
            i_sel = i_head.i_e;
            q_sel = i_head.q_e;
         end
         PH_PROMPT: begin
            i_sel = i_head.i_p;
            q_sel = i_head.q_p;
         end
         default: begin
            i_sel = i_head.i_l;
            q_sel = i_head.q_l;
         end
      endcase
   end

   assign i_mag = abs_mag(i_sel);
   assign q_mag = abs_mag(q_sel);

   //////////////////////////////////////////////////////////////////////
   // Square, sum and collect
   //////////////////////////////////////////////////////////////////////

   // Phase markers follow the data through both stages.
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ph_sq       <= PH_IDLE;
         ph_sum      <= PH_IDLE;
         o_pwr_valid <= 1'b0;
      end else begin
         ph_sq       <= phase;
         ph_sum      <= ph_sq;
         o_pwr_valid <= (ph_sum == PH_LATE);
      end
   end

   always_ff @(posedge clk) begin
      i_sq    <= PWR_W'(i_mag * i_mag);
      q_sq    <= PWR_W'(q_mag * q_mag);
      tag_sq  <= i_head.tag;
      pwr_sum <= i_sq + q_sq;
      tag_sum <= tag_sq;
      case (ph_sum)
         PH_EARLY: begin
            o_pwr.tag       <= tag_sum;
            o_pwr.pwr_early <= pwr_sum;
         end
         PH_PROMPT: o_pwr.pwr_prompt <= pwr_sum;
         PH_LATE:   o_pwr.pwr_late   <= pwr_sum;
         default: ;
      endcase
   end

endmodule

// File: rtl/tl_pkg.sv
package tl_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   localparam int ACC_W    = 19;
   localparam int MAG_W    = 18;
   localparam int PWR_W    = 37;
   localparam int DISC_W   = 38;
   localparam int TAU_W    = 15;
   localparam int TAG_W    = 2;
   localparam int NUM_TAGS = 4;

   // Accumulation buffer geometry.
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
   localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

   // Loop gain as a right shift of the discriminator.
   localparam int DLL_GAIN_SHIFT = 20;

   //////////////////////////////////////////////////////////////////////
   // Records
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [TAG_W-1:0]        tag;
      logic signed [ACC_W-1:0] i_e;
      logic signed [ACC_W-1:0] q_e;
      logic signed [ACC_W-1:0] i_p;
      logic signed [ACC_W-1:0] q_p;
      logic signed [ACC_W-1:0] i_l;
      logic signed [ACC_W-1:0] q_l;
   } acc_rec_t;

   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [PWR_W-1:0] pwr_early;
      logic [PWR_W-1:0] pwr_prompt;
      logic [PWR_W-1:0] pwr_late;
   } pwr_rec_t;

   typedef struct packed {
      logic [TAG_W-1:0]         tag;
      logic signed [DISC_W-1:0] disc;
      logic [TAU_W-1:0]         tau;
   } dll_result_t;

   // Which subchannel the power stage is working on.
   typedef enum logic [1:0] {
      PH_IDLE,
      PH_EARLY,
      PH_PROMPT,
      PH_LATE
   } pwr_phase_e;

endpackage

// File: rtl/tracking_loop_top.sv
`timescale 1ns/1ps

module tracking_loop_top
   import tl_pkg::*;
(
   input  logic              clk,
   input  logic              i_arst_n,
   input  logic              i_acc_valid,
   input  acc_rec_t          i_acc,
   input  logic [TAG_W-1:0]  i_host_addr,
   input  logic              i_host_wr,
   input  logic [TAU_W-1:0]  i_host_wdata,
   output logic [TAU_W-1:0]  o_host_rdata,
   output logic              o_overflow,
   output logic              o_update_valid,
   output dll_result_t       o_update
);

   logic     fifo_empty;
   acc_rec_t fifo_head;
   logic     fifo_pop;
   logic     pwr_valid;
   pwr_rec_t pwr_rec;

   // Correlator results wait here.
   acc_fifo acc_fifo_inst (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_push     (i_acc_valid),
      .i_data     (i_acc),
      .i_pop      (fifo_pop),
      .o_empty    (fifo_empty),
      .o_head     (fifo_head),
      .o_overflow (o_overflow)
   );

   // Early, prompt and late power, one record at a time.
   power_calc power_calc_inst (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_empty     (fifo_empty),
      .i_head      (fifo_head),
      .o_pop       (fifo_pop),
      .o_pwr_valid (pwr_valid),
      .o_pwr       (pwr_rec)
   );

   // Code loop.
   dll_update dll_update_inst (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_pwr_valid    (pwr_valid),
      .i_pwr          (pwr_rec),
      .i_host_addr    (i_host_addr),
      .i_host_wr      (i_host_wr),
      .i_host_wdata   (i_host_wdata),
      .o_host_rdata   (o_host_rdata),
      .o_update_valid (o_update_valid),
      .o_update       (o_update)
   );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS = 40
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   // Free running, half period high.
   always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: sim/tb_tracking_loop.sv
`timescale 1ns/1ps

module tb_tracking_loop
   import tl_pkg::*;
();

   logic               clk;
   logic               arst_n;
   logic               acc_valid;
   acc_rec_t           acc;
   logic [TAG_W-1:0]   host_addr;
   logic               host_wr;
   logic [TAU_W-1:0]   host_wdata;
   logic [TAU_W-1:0]   host_rdata;
   logic               overflow;
   logic               update_valid;
   dll_result_t        update;

   int     value_errs;
   int     other_errs;
   int     cycle;
   int     limit_cycles;
   int     push_cycle;
   bit     timed;
   longint fld [7];

   // Pending update expectations in arrival order.
   string  exp_name [$];
   longint exp_tag [$];
   longint exp_pe [$];
   longint exp_pp [$];
   longint exp_pl [$];
   longint exp_disc [$];
   longint exp_tau [$];

   tb_clock #(.PERIOD_NS(40)) tb_clock_inst (.o_clk(clk));

   tracking_loop_top tracking_loop_top_inst (
      .clk            (clk),
      .i_arst_n       (arst_n),
      .i_acc_valid    (acc_valid),
      .i_acc          (acc),
      .i_host_addr    (host_addr),
      .i_host_wr      (host_wr),
      .i_host_wdata   (host_wdata),
      .o_host_rdata   (host_rdata),
      .o_overflow     (overflow),
      .o_update_valid (update_valid),
      .o_update       (update)
   );

   task automatic check_value(input string name, input string field,
                              input longint expv, input longint actv);
      assert (expv == actv) else begin
         $display("Fail %s %s expected %0d actual %0d", name, field, expv, actv);
         value_errs++;
      end
   endtask

   task automatic compare_update();
      string  name;
      longint d;
      name = exp_name.pop_front();
      d    = $signed(update.disc);
      check_value(name, "tag", exp_tag.pop_front(), update.tag);
      check_value(name, "disc", exp_disc.pop_front(), d);
      check_value(name, "tau", exp_tau.pop_front(), update.tau);
      // Powers are read at the power stage output inside the DUT.
      check_value(name, "pwr_early", exp_pe.pop_front(),
                  tracking_loop_top_inst.pwr_rec.pwr_early);
      check_value(name, "pwr_prompt", exp_pp.pop_front(),
                  tracking_loop_top_inst.pwr_rec.pwr_prompt);
      check_value(name, "pwr_late", exp_pl.pop_front(),
                  tracking_loop_top_inst.pwr_rec.pwr_late);
      if (timed) begin
         timed = 1'b0;
         check_value(name, "latency", 8, cycle - push_cycle);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Update monitor
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (arst_n && update_valid) begin
         if (exp_name.size() == 0) begin
            $display("Update for tag %0d arrived with nothing expected", update.tag);
            other_errs++;
         end else begin
            compare_update();
         end
      end
   end

   task automatic idle_cycle();
      @(posedge clk);
      acc_valid <= 1'b0;
      host_wr   <= 1'b0;
   endtask

   task automatic wait_drained();
      while (exp_name.size() != 0) begin
         idle_cycle();
      end
   endtask

   task automatic push_record(input bit single);
      acc_rec_t rec;
      rec.tag = fld[0][TAG_W-1:0];
      rec.i_e = fld[1][ACC_W-1:0];
      rec.q_e = fld[2][ACC_W-1:0];
      rec.i_p = fld[3][ACC_W-1:0];
      rec.q_p = fld[4][ACC_W-1:0];
      rec.i_l = fld[5][ACC_W-1:0];
      rec.q_l = fld[6][ACC_W-1:0];
      @(posedge clk);
      acc_valid <= 1'b1;
      acc       <= rec;
      host_wr   <= 1'b0;
      if (single) begin
         timed      = 1'b1;
         // The DUT takes the record at the next edge.
         push_cycle = cycle + 1;
      end
   endtask

   task automatic run_command(input string line);
      byte   c;
      string name;
      int    n;
      case (line[0])
         "A", "B": begin
            n = $sscanf(line, "%c %d %d %d %d %d %d %d", c, fld[0], fld[1], fld[2],
                        fld[3], fld[4], fld[5], fld[6]);
            if (n != 8) begin
               $display("Malformed trace line: %s", line);
               other_errs++;
            end else if (c == "A") begin
               // Single record into an idle pipeline.
               wait_drained();
               repeat ($urandom % 4) idle_cycle();
               push_record(1'b1);
            end else begin
               push_record(1'b0);
            end
         end
         "X": begin
            n = $sscanf(line, "%c %s %d %d %d %d %d %d", c, name, fld[0], fld[1],
                        fld[2], fld[3], fld[4], fld[5]);
            exp_name.push_back(name);
            exp_tag.push_back(fld[0]);
            exp_pe.push_back(fld[1]);
            exp_pp.push_back(fld[2]);
            exp_pl.push_back(fld[3]);
            exp_disc.push_back(fld[4]);
            exp_tau.push_back(fld[5]);
         end
         "W": begin
            n = $sscanf(line, "%c %d %d", c, fld[0], fld[1]);
            wait_drained();
            @(posedge clk);
            acc_valid  <= 1'b0;
            host_wr    <= 1'b1;
            host_addr  <= fld[0][TAG_W-1:0];
            host_wdata <= fld[1][TAU_W-1:0];
         end
         "R": begin
            n = $sscanf(line, "%c %d %d", c, fld[0], fld[1]);
            wait_drained();
            @(posedge clk);
            acc_valid <= 1'b0;
            host_wr   <= 1'b0;
            host_addr <= fld[0][TAG_W-1:0];
            // Registered read data is stable two edges later.
            idle_cycle();
            idle_cycle();
            check_value("host_read", "rdata", fld[1], host_rdata);
         end
         "O": begin
            n = $sscanf(line, "%c %d", c, fld[0]);
            wait_drained();
            idle_cycle();
            check_value("overflow", "flag", fld[0], overflow);
         end
         default: begin
            $display("Unknown trace command: %s", line);
            other_errs++;
         end
      endcase
   endtask

   //////////////////////////////////////////////////////////////////////
   // Watchdog
   //////////////////////////////////////////////////////////////////////

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("sim failed");
      $finish;
   end

   initial begin
      int    fd;
      int    lines;
      int    k;
      string line;
      void'($urandom(32'he3d2b389));
      arst_n     = 1'b0;
      acc_valid  = 1'b0;
      acc        = '0;
      host_addr  = '0;
      host_wr    = 1'b0;
      host_wdata = '0;
      cycle      = 0;
      timed      = 1'b0;
      value_errs = 0;
      other_errs = 0;
      lines      = 0;
      fd = $fopen("sim/tracking_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file");
         other_errs++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            lines++;
         end
         $fclose(fd);
         fd = $fopen("sim/tracking_trace.txt", "r");
      end
      limit_cycles = lines * 20 + 100;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               run_command(line);
            end
         end
         $fclose(fd);
      end
      k = 0;
      while (exp_name.size() != 0 && k < 50) begin
         idle_cycle();
         k++;
      end
      if (exp_name.size() != 0) begin
         $display("%0d expected updates never arrived", exp_name.size());
         other_errs++;
      end
      repeat (4) idle_cycle();
      $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: sim/tracking_trace.txt
# A/B tag ie qe ip qp il ql | W addr data | R addr expected | O expected
# X name tag pwr_early pwr_prompt pwr_late disc tau (all decimal)
A 0 3000 -4000 100 -200 1000 0
X pwr_basic 0 25000000 50000 1000000 24000000 22
O 0
A 1 -262144 0 -1 -1 5000 5000
X most_neg 1 68719476736 2 50000000 68669476736 32720
A 1 0 0 7 -7 -3000 4000
X tau_neg 1 0 98 25000000 -25000000 32696
A 1 200000 0 0 0 0 0
X tau_wrap 1 40000000000 0 0 40000000000 5306
A 2 2000 0 0 0 0 0
X tag2_a 2 4000000 0 0 4000000 3
A 3 0 0 0 0 2000 0
X tag3_a 3 0 0 4000000 -4000000 32764
B 3 0 0 0 0 2000 0
B 2 2000 0 0 0 0 0
X tag3_b 3 0 0 4000000 -4000000 32760
X tag2_b 2 4000000 0 0 4000000 6
W 0 1000
R 0 1000
A 0 3000 -4000 100 -200 1000 0
X host_seed 0 25000000 50000 1000000 24000000 1022
R 1 5306
B 0 1000 0 0 0 0 0
B 0 2000 0 0 0 0 0
B 0 3000 0 0 0 0 0
B 0 4000 0 0 0 0 0
B 0 5000 0 0 0 0 0
B 0 6000 0 0 0 0 0
X burst_1 0 1000000 0 0 1000000 1022
X burst_2 0 4000000 0 0 4000000 1025
X burst_3 0 9000000 0 0 9000000 1033
X burst_4 0 16000000 0 0 16000000 1048
X burst_5 0 25000000 0 0 25000000 1071
O 1
R 0 1071
